// ==== exu_top.f ====
+incdir+verification
common/exu_pkg.sv
alu/alu_core.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
design/operand_latch.sv
design/result_select.sv
design/exu_top.sv
verification/exu_tb.sv

// ==== Bender.yml ====
package:
  name: exu_top

sources:
  - common/exu_pkg.sv
  - alu/alu_core.sv
  - muldiv/mul_unit.sv
  - muldiv/div_unit.sv
  - design/operand_latch.sv
  - design/result_select.sv
  - design/exu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exu_tb.sv

// ==== verification/exu_ref_model.svh ====
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

function automatic xlen_t sext_word(input xlen_t v);
  return {{(XLEN-32){v[31]}}, v[31:0]};
endfunction

// signed or unsigned compare of the full operands
function automatic logic ref_less(input alu_op_t op, input xlen_t a, input xlen_t b);
  if (op[ALU_VAR_BIT]) begin
    return a < b;
  end
  return $signed(a) < $signed(b);
endfunction

function automatic xlen_t ref_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
  xlen_t              r;
  logic signed [31:0] w;
  logic signed [63:0] s;
  case (op[2:0])
    ALU_ADD:  r = op[ALU_VAR_BIT] ? a - b : a + b;
    ALU_SLL:  r = op[ALU_WORD_BIT] ? a << b[4:0] : a << b[5:0];
    ALU_SLT:  r = {{(XLEN-1){1'b0}}, ref_less(op, a, b)};
    ALU_SRC2: r = b;
    ALU_XOR:  r = a ^ b;
    ALU_SR: begin
      if (op[ALU_WORD_BIT]) begin
        w = a[31:0];
        if (op[ALU_VAR_BIT]) begin
          w = w >>> b[4:0];
        end else begin
          w = a[31:0] >> b[4:0];
        end
        r = {{(XLEN-32){w[31]}}, w};
      end else if (op[ALU_VAR_BIT]) begin
        s = a;
        s = s >>> b[5:0];
        r = s;
      end else begin
        r = a >> b[5:0];
      end
    end
    ALU_OR:   r = a | b;
    default:  r = a & b;
  endcase
  return op[ALU_WORD_BIT] ? sext_word(r) : r;
endfunction

// full 128-bit product, operands extended by their signedness
function automatic xlen_t ref_mul(input md_type_t t, input xlen_t a, input xlen_t b);
  logic [2*XLEN-1:0] ea;
  logic [2*XLEN-1:0] eb;
  logic [2*XLEN-1:0] p;
  ea = {{XLEN{1'b0}}, a};
  eb = {{XLEN{1'b0}}, b};
  if (t == MD_MULH || t == MD_MULHSU) begin
    ea = {{XLEN{a[XLEN-1]}}, a};
  end
  if (t == MD_MULH) begin
    eb = {{XLEN{b[XLEN-1]}}, b};
  end
  p = ea * eb;
  return (t == MD_MUL) ? p[XLEN-1:0] : p[2*XLEN-1:XLEN];
endfunction

function automatic xlen_t ref_div(input md_type_t t, input xlen_t a, input xlen_t b);
  xlen_t min_val;
  logic  ovf;
  xlen_t r;
  min_val = {1'b1, {(XLEN-1){1'b0}}};
  ovf     = (a == min_val) && (b == '1);
  case (t)
    MD_DIV: begin
      if (b == '0) r = '1;
      else if (ovf) r = a;
      else r = $signed(a) / $signed(b);
    end
    MD_DIVU: r = (b == '0) ? '1 : a / b;
    MD_REM: begin
      if (b == '0) r = a;
      else if (ovf) r = '0;
      else r = $signed(a) % $signed(b);
    end
    default: r = (b == '0) ? a : a % b;
  endcase
  return r;
endfunction

function automatic xlen_t ref_muldiv(input muldiv_op_t op, input logic word,
                                     input xlen_t a, input xlen_t b);
  xlen_t r;
  r = op[MD_DIV_BIT] ? ref_div(op[1:0], a, b) : ref_mul(op[1:0], a, b);
  return word ? sext_word(r) : r;
endfunction

`endif

// ==== verification/exu_tb.sv ====
`timescale 1ns/100ps

module exu_tb;
  import exu_pkg::*;

  `include "exu_ref_model.svh"

  localparam int MUL_STEP_BITS = 4;
  localparam int MUL_LAT       = XLEN / MUL_STEP_BITS;
  // setup cycle, one cycle per quotient bit, done shows in fixup
  localparam int DIV_LAT       = XLEN + 2;
  localparam int N_RANDOM      = 400;
  localparam int N_TESTS       = N_RANDOM + 32 * 9 + 40;
  localparam int TIMEOUT_NS    = N_TESTS * 70 * 4 * 2;

  logic       clk;
  logic       rst_n;
  alu_op_t    alu_op_i;
  xlen_t      src1_i;
  xlen_t      src2_i;
  logic       muldiv_en_i;
  muldiv_op_t muldiv_op_i;
  logic       flush_i;
  xlen_t      result_o;
  logic       less_o;
  logic       zero_o;
  logic       stall_o;
  logic [31:0] lfsr_q;
  // last instruction was a muldiv, so the next start slips a cycle
  logic       prev_md;

  exu_top #(
    .MUL_STEP_BITS (MUL_STEP_BITS)
  ) exu_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .alu_op_i    (alu_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .muldiv_en_i (muldiv_en_i),
    .muldiv_op_i (muldiv_op_i),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .less_o      (less_o),
    .zero_o      (zero_o),
    .stall_o     (stall_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  initial begin
    #(TIMEOUT_NS);
    abort_run("timeout, the tests did not finish in the expected time");
  end

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[XLEN-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic xlen_t edge_value(input int k);
    xlen_t v;
    case (k)
      0:       v = '0;
      1:       v = '1;
      default: v = {1'b1, {(XLEN-1){1'b0}}};
    endcase
    return v;
  endfunction

  // edge values with some weight, random words otherwise
  function automatic xlen_t pick_operand();
    logic [2:0] kind;
    kind = 3'(rand_bits(3));
    if (kind < 3'd3) begin
      return edge_value(int'(kind));
    end
    return rand_bits(XLEN);
  endfunction

  task automatic run_alu(input alu_op_t op, input xlen_t a, input xlen_t b);
    string name;
    name = $sformatf("alu op %02h a %h b %h", op, a, b);
    @(negedge clk);
    alu_op_i    = op;
    src1_i      = a;
    src2_i      = b;
    muldiv_en_i = 1'b0;
    flush_i     = 1'b0;
    #1;
    check_word(name, ref_alu(op, a, b), result_o);
    check_flag({name, " stall"}, 1'b0, stall_o);
    if (op[2:0] == ALU_SLT || (op[2:0] == ALU_ADD && op[ALU_VAR_BIT])) begin
      check_flag({name, " less"}, ref_less(op, a, b), less_o);
      check_flag({name, " zero"}, a == b, zero_o);
    end
    prev_md = 1'b0;
  endtask

  task automatic run_muldiv(input muldiv_op_t op, input logic word,
                            input xlen_t a, input xlen_t b);
    string name;
    int    cycles;
    int    exp_lat;
    name    = $sformatf("muldiv op %0d word %b a %h b %h", op, word, a, b);
    exp_lat = (op[MD_DIV_BIT] ? DIV_LAT : MUL_LAT) + (prev_md ? 1 : 0);
    cycles  = 0;
    @(negedge clk);
    alu_op_i    = {word, 4'b0000};
    src1_i      = a;
    src2_i      = b;
    muldiv_op_i = op;
    muldiv_en_i = 1'b1;
    flush_i     = 1'b0;
    #1;
    check_flag({name, " stall at issue"}, 1'b1, stall_o);
    while (stall_o) begin
      @(negedge clk);
      cycles++;
      if (cycles > DIV_LAT + 8) begin
        abort_run({name, " never released stall_o"});
      end
    end
    if (cycles != exp_lat) begin
      abort_run($sformatf("mismatch %s stall cycles expected %0d actual %0d",
                          name, exp_lat, cycles));
    end
    check_word(name, ref_muldiv(op, word, a, b), result_o);
    prev_md = 1'b1;
  endtask

  task automatic flush_divide(input xlen_t a, input xlen_t b);
    @(negedge clk);
    alu_op_i    = '0;
    src1_i      = a;
    src2_i      = b;
    muldiv_op_i = 3'b100;
    muldiv_en_i = 1'b1;
    flush_i     = 1'b0;
    repeat (20) @(negedge clk);
    check_flag("divide before flush stall", 1'b1, stall_o);
    flush_i = 1'b1;
    #1;
    check_flag("flush stall", 1'b0, stall_o);
    @(negedge clk);
    muldiv_en_i = 1'b0;
    flush_i     = 1'b0;
    prev_md = 1'b0;
  endtask

  initial begin : stimulus
    xlen_t      a;
    xlen_t      b;
    muldiv_op_t md_op;
    logic       word;
    lfsr_q      = 32'd4062;
    prev_md     = 1'b0;
    rst_n       = 1'b0;
    alu_op_i    = '0;
    src1_i      = '0;
    src2_i      = '0;
    muldiv_en_i = 1'b0;
    muldiv_op_i = '0;
    flush_i     = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_flag("stall after reset", 1'b0, stall_o);

    // every ALU code against all pairs of edge values
    for (int f = 0; f < 32; f++) begin
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          run_alu(alu_op_t'(f), edge_value(i), edge_value(j));
        end
      end
    end

    for (int t = 0; t < 4; t++) begin
      run_muldiv(muldiv_op_t'(t), 1'b0, edge_value(2), '1);
      run_muldiv(muldiv_op_t'(t), 1'b0, '1, '1);
      run_muldiv(muldiv_op_t'(t), t == 0, rand_bits(XLEN), rand_bits(XLEN));
    end

    // zero divisor and min / -1
    for (int t = 0; t < 4; t++) begin
      run_muldiv(muldiv_op_t'(4 + t), 1'b0, rand_bits(XLEN), '0);
      run_muldiv(muldiv_op_t'(4 + t), 1'b0, edge_value(2), '1);
      run_muldiv(muldiv_op_t'(4 + t), 1'b0, rand_bits(XLEN), rand_bits(XLEN));
    end

    // same instruction twice in a row
    a = rand_bits(XLEN);
    b = rand_bits(XLEN);
    run_muldiv(3'b001, 1'b0, a, b);
    run_muldiv(3'b001, 1'b0, a, b);
    run_muldiv(3'b110, 1'b0, a, b);
    run_muldiv(3'b110, 1'b0, a, b);

    flush_divide(rand_bits(XLEN), rand_bits(XLEN));
    run_muldiv(3'b100, 1'b0, a, b);
    run_alu(alu_op_t'(ALU_ADD), a, b);

    for (int n = 0; n < N_RANDOM; n++) begin
      a = pick_operand();
      b = pick_operand();
      if (rand_bits(2) == '0) begin
        md_op = muldiv_op_t'(rand_bits(3));
        word  = rand_bits(1) != '0;
        run_muldiv(md_op, word, a, b);
      end else begin
        run_alu(alu_op_t'(rand_bits(5)), a, b);
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== design/exu_top.sv ====
`timescale 1ns/100ps

module exu_top #(
  parameter int MUL_STEP_BITS = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  exu_pkg::alu_op_t    alu_op_i,
  input  exu_pkg::xlen_t      src1_i,
  input  exu_pkg::xlen_t      src2_i,
  input  logic                muldiv_en_i,
  input  exu_pkg::muldiv_op_t muldiv_op_i,
  input  logic                flush_i,
  output exu_pkg::xlen_t      result_o,
  output logic                less_o,
  output logic                zero_o,
  output logic                stall_o
);
  import exu_pkg::*;

  logic     mul_start;
  logic     div_start;
  logic     mul_done;
  logic     div_done;
  xlen_t    op_a;
  xlen_t    op_b;
  md_type_t md_type;
  xlen_t    alu_res;
  xlen_t    mul_res;
  xlen_t    div_res;

  operand_latch operand_latch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .muldiv_en_i (muldiv_en_i),
    .muldiv_op_i (muldiv_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .flush_i     (flush_i),
    .mul_done_i  (mul_done),
    .div_done_i  (div_done),
    .mul_start_o (mul_start),
    .div_start_o (div_start),
    .op_a_o      (op_a),
    .op_b_o      (op_b),
    .md_type_o   (md_type)
  );

  alu_core alu_core_i (
    .alu_op_i  (alu_op_i),
    .src1_i    (src1_i),
    .src2_i    (src2_i),
    .alu_res_o (alu_res),
    .less_o    (less_o),
    .zero_o    (zero_o)
  );

  mul_unit #(
    .MUL_STEP_BITS (MUL_STEP_BITS)
  ) mul_unit_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .flush_i  (flush_i),
    .type_i   (md_type),
    .a_i      (op_a),
    .b_i      (op_b),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  div_unit div_unit_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .flush_i  (flush_i),
    .type_i   (md_type),
    .a_i      (op_a),
    .b_i      (op_b),
    .done_o   (div_done),
    .result_o (div_res)
  );

  result_select result_select_i (
    .alu_op_i    (alu_op_i),
    .muldiv_en_i (muldiv_en_i),
    .muldiv_op_i (muldiv_op_i),
    .flush_i     (flush_i),
    .alu_res_i   (alu_res),
    .mul_res_i   (mul_res),
    .div_res_i   (div_res),
    .mul_done_i  (mul_done),
    .div_done_i  (div_done),
    .result_o    (result_o),
    .stall_o     (stall_o)
  );

endmodule

// ==== design/result_select.sv ====
`timescale 1ns/100ps

module result_select (
  input  exu_pkg::alu_op_t    alu_op_i,
  input  logic                muldiv_en_i,
  input  exu_pkg::muldiv_op_t muldiv_op_i,
  input  logic                flush_i,
  input  exu_pkg::xlen_t      alu_res_i,
  input  exu_pkg::xlen_t      mul_res_i,
  input  exu_pkg::xlen_t      div_res_i,
  input  logic                mul_done_i,
  input  logic                div_done_i,
  output exu_pkg::xlen_t      result_o,
  output logic                stall_o
);
  import exu_pkg::*;

  xlen_t raw;
  logic  md_done;

  always_comb begin
    if (muldiv_en_i) begin
      raw = muldiv_op_i[MD_DIV_BIT] ? div_res_i : mul_res_i;
    end else begin
      raw = alu_res_i;
    end
  end

  // word form, also gives mulw from the low product half
  assign result_o = alu_op_i[ALU_WORD_BIT] ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

  // only the unit that runs this instruction releases the stall
  assign md_done = muldiv_op_i[MD_DIV_BIT] ? div_done_i : mul_done_i;
  assign stall_o = muldiv_en_i & ~flush_i & ~md_done;

endmodule

// ==== design/operand_latch.sv ====
`timescale 1ns/100ps

module operand_latch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                muldiv_en_i,
  input  exu_pkg::muldiv_op_t muldiv_op_i,
  input  exu_pkg::xlen_t      src1_i,
  input  exu_pkg::xlen_t      src2_i,
  input  logic                flush_i,
  input  logic                mul_done_i,
  input  logic                div_done_i,
  output logic                mul_start_o,
  output logic                div_start_o,
  output exu_pkg::xlen_t      op_a_o,
  output exu_pkg::xlen_t      op_b_o,
  output exu_pkg::md_type_t   md_type_o
);
  import exu_pkg::*;

  logic     busy_q;
  logic     done_last_q;
  logic     md_done;
  logic     start;
  xlen_t    a_q;
  xlen_t    b_q;
  md_type_t type_q;

  assign md_done = mul_done_i | div_done_i;

  // the cycle after a done still carries the old instruction
  assign start = muldiv_en_i & ~busy_q & ~done_last_q & ~flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      done_last_q <= 1'b0;
    end else begin
      done_last_q <= md_done;
      if (flush_i) begin
        busy_q <= 1'b0;
      end else if (start) begin
        busy_q <= 1'b1;
      end else if (md_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      a_q    <= src1_i;
      b_q    <= src2_i;
      type_q <= muldiv_op_i[1:0];
    end
  end

  // live inputs in the start cycle, held copies afterwards
  assign op_a_o    = start ? src1_i : a_q;
  assign op_b_o    = start ? src2_i : b_q;
  assign md_type_o = start ? muldiv_op_i[1:0] : type_q;

  assign mul_start_o = start & ~muldiv_op_i[MD_DIV_BIT];
  assign div_start_o = start & muldiv_op_i[MD_DIV_BIT];

  a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
    !(mul_start_o && div_start_o));

endmodule

// ==== muldiv/div_unit.sv ====
`timescale 1ns/100ps

module div_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic              flush_i,
  input  exu_pkg::md_type_t type_i,
  input  exu_pkg::xlen_t    a_i,
  input  exu_pkg::xlen_t    b_i,
  output logic              done_o,
  output exu_pkg::xlen_t    result_o
);
  import exu_pkg::*;

  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {DIV_IDLE, DIV_SETUP, DIV_RUN, DIV_FIXUP} div_state_t;

  div_state_t        state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              signed_op;
  logic              rem_op;
  logic              neg_a;
  logic              neg_b;
  xlen_t             mag_a;
  xlen_t             mag_b;
  xlen_t             rem_q;
  xlen_t             quo_q;
  xlen_t             dvs_q;
  logic              neg_quo_q;
  logic              neg_rem_q;
  logic              zero_q;
  logic              rem_sel_q;
  logic [XLEN:0]     trial;
  logic [XLEN+1:0]   diff;
  logic              fits;
  xlen_t             quo_fix;
  xlen_t             rem_fix;

  always_comb begin
    signed_op = 1'b0;
    rem_op    = 1'b0;
    case (type_i)
      MD_DIV:  signed_op = 1'b1;
      MD_DIVU: signed_op = 1'b0;
      MD_REM: begin
        signed_op = 1'b1;
        rem_op    = 1'b1;
      end
      MD_REMU: rem_op = 1'b1;
      default: signed_op = 1'b0;
    endcase
  end

  // setup reads the operands that operand_latch keeps after start
  assign neg_a = signed_op & a_i[XLEN-1];
  assign neg_b = signed_op & b_i[XLEN-1];
  assign mag_a = neg_a ? -a_i : a_i;
  assign mag_b = neg_b ? -b_i : b_i;

  // one restoring step: shift in the next dividend bit, try to subtract
  assign trial = {rem_q, quo_q[XLEN-1]};
  assign diff  = {1'b0, trial} - {2'b00, dvs_q};
  assign fits  = ~diff[XLEN+1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            state_q <= DIV_SETUP;
          end
        end
        DIV_SETUP: begin
          cnt_q   <= '0;
          state_q <= DIV_RUN;
        end
        DIV_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == {CNT_W{1'b1}}) begin
            state_q <= DIV_FIXUP;
          end
        end
        DIV_FIXUP: state_q <= DIV_IDLE;
        default:   state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == DIV_SETUP) begin
      quo_q     <= mag_a;
      dvs_q     <= mag_b;
      rem_q     <= '0;
      neg_quo_q <= neg_a ^ neg_b;
      neg_rem_q <= neg_a;
      zero_q    <= (b_i == '0);
      rem_sel_q <= rem_op;
    end else if (state_q == DIV_RUN) begin
      rem_q <= fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], fits};
    end
  end

  // divide by zero leaves rem = |a|, so only the quotient is forced.
  // min / -1 comes out as min with rem 0 from the magnitude path
  assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  assign result_o = rem_sel_q ? rem_fix : quo_fix;
  assign done_o   = (state_q == DIV_FIXUP);

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o);

endmodule

// ==== muldiv/mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit #(
  parameter int MUL_STEP_BITS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic              flush_i,
  input  exu_pkg::md_type_t type_i,
  input  exu_pkg::xlen_t    a_i,
  input  exu_pkg::xlen_t    b_i,
  output logic              done_o,
  output exu_pkg::xlen_t    result_o
);
  import exu_pkg::*;

  // MUL_STEP_BITS has to divide XLEN and stay below it
  localparam int STEPS = XLEN / MUL_STEP_BITS;
  localparam int CNT_W = $clog2(STEPS) + 1;

  typedef enum logic {MUL_IDLE, MUL_RUN} mul_state_t;

  mul_state_t          state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                a_signed;
  logic                b_signed;
  logic                neg_a;
  logic                neg_b;
  logic                neg_q;
  logic                hi_q;
  logic                neg_cur;
  logic                hi_cur;
  logic                active;
  logic                last_step;
  xlen_t               mag_a;
  xlen_t               mag_b;
  xlen_t               mplier_q;
  xlen_t               cur_mplier;
  xlen_t               result_q;
  logic [2*XLEN-1:0]   acc_q;
  logic [2*XLEN-1:0]   mcand_q;
  logic [2*XLEN-1:0]   cur_acc;
  logic [2*XLEN-1:0]   cur_mcand;
  logic [2*XLEN-1:0]   acc_nxt;
  logic [2*XLEN-1:0]   prod;

  always_comb begin
    a_signed = 1'b0;
    b_signed = 1'b0;
    case (type_i)
      MD_MUL:    a_signed = 1'b0;
      MD_MULH: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      MD_MULHSU: a_signed = 1'b1;
      MD_MULHU:  b_signed = 1'b0;
      default:   a_signed = 1'b0;
    endcase
  end

  assign neg_a = a_signed & a_i[XLEN-1];
  assign neg_b = b_signed & b_i[XLEN-1];
  assign mag_a = neg_a ? -a_i : a_i;
  assign mag_b = neg_b ? -b_i : b_i;

  assign active    = start_i | (state_q == MUL_RUN);
  assign last_step = (state_q == MUL_RUN) & (cnt_q == CNT_W'(STEPS - 1));

  // first group of partial products is added in the start cycle
  assign cur_acc    = start_i ? '0 : acc_q;
  assign cur_mcand  = start_i ? {{XLEN{1'b0}}, mag_a} : mcand_q;
  assign cur_mplier = start_i ? mag_b : mplier_q;
  assign neg_cur    = start_i ? (neg_a ^ neg_b) : neg_q;
  assign hi_cur     = start_i ? (type_i != MD_MUL) : hi_q;

  always_comb begin
    acc_nxt = cur_acc;
    for (int j = 0; j < MUL_STEP_BITS; j++) begin
      if (cur_mplier[j]) begin
        acc_nxt = acc_nxt + (cur_mcand << j);
      end
    end
  end

  assign prod = neg_cur ? -acc_nxt : acc_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end else if (flush_i) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= last_step;
      case (state_q)
        MUL_IDLE: begin
          if (start_i) begin
            state_q <= MUL_RUN;
            cnt_q   <= CNT_W'(1);
          end
        end
        MUL_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_step) begin
            state_q <= MUL_IDLE;
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      acc_q    <= acc_nxt;
      mcand_q  <= cur_mcand << MUL_STEP_BITS;
      mplier_q <= cur_mplier >> MUL_STEP_BITS;
      neg_q    <= neg_cur;
      hi_q     <= hi_cur;
    end
    if (last_step) begin
      result_q <= hi_cur ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    end
  end

  assign result_o = result_q;

  // operand_latch holds off a new start until this unit is done
  a_no_start_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == MUL_IDLE));

endmodule

// ==== alu/alu_core.sv ====
`timescale 1ns/100ps

module alu_core (
  input  exu_pkg::alu_op_t alu_op_i,
  input  exu_pkg::xlen_t   src1_i,
  input  exu_pkg::xlen_t   src2_i,
  output exu_pkg::xlen_t   alu_res_o,
  output logic             less_o,
  output logic             zero_o
);
  import exu_pkg::*;

  logic [2:0]  func;
  logic        variant;
  logic        word;
  logic        cin;
  xlen_t       b_opd;
  xlen_t       sum;
  logic        carry;
  logic        overflow;
  logic        is_left;
  logic        arith;
  logic        fill;
  shamt_t      shamt;
  xlen_t       shift_src;
  xlen_t       sh_in;
  logic [XLEN:0] sh_wide;
  xlen_t       shift_res;

  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  assign func    = alu_op_i[2:0];
  assign variant = alu_op_i[ALU_VAR_BIT];
  assign word    = alu_op_i[ALU_WORD_BIT];

  // one adder for add, sub and slt
  assign cin   = variant | (func == ALU_SLT);
  assign b_opd = src2_i ^ {XLEN{cin}};
  assign {carry, sum} = {1'b0, src1_i} + {1'b0, b_opd} + {{XLEN{1'b0}}, cin};

  assign overflow = (src1_i[XLEN-1] == b_opd[XLEN-1]) & (sum[XLEN-1] != src1_i[XLEN-1]);

  // unsigned: no carry out of a + ~b + 1 means a < b
  assign less_o = variant ? ~carry : (sum[XLEN-1] ^ overflow);
  assign zero_o = ~|sum;

  // shifter, left shifts go through the same right shifter reversed
  assign is_left = (func == ALU_SLL);
  assign arith   = variant & (func == ALU_SR);
  assign shamt   = word ? {1'b0, src2_i[4:0]} : src2_i[5:0];

  // word form works on the low half, upper bits pre-filled for sraw
  assign shift_src = word ? {{(XLEN-32){arith & src1_i[31]}}, src1_i[31:0]} : src1_i;
  assign sh_in     = is_left ? bit_rev(shift_src) : shift_src;
  assign fill      = arith & sh_in[XLEN-1];
  assign sh_wide   = $signed({fill, sh_in}) >>> shamt;
  assign shift_res = is_left ? bit_rev(sh_wide[XLEN-1:0]) : sh_wide[XLEN-1:0];

  always_comb begin
    case (func)
      ALU_ADD:  alu_res_o = sum;
      ALU_SLL:  alu_res_o = shift_res;
      ALU_SLT:  alu_res_o = {{(XLEN-1){1'b0}}, less_o};
      ALU_SRC2: alu_res_o = src2_i;
      ALU_XOR:  alu_res_o = src1_i ^ src2_i;
      ALU_SR:   alu_res_o = shift_res;
      ALU_OR:   alu_res_o = src1_i | src2_i;
      ALU_AND:  alu_res_o = src1_i & src2_i;
      default:  alu_res_o = sum;
    endcase
  end

endmodule

// ==== common/exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      alu_op_t;
  typedef logic [2:0]      muldiv_op_t;
  typedef logic [1:0]      md_type_t;
  typedef logic [5:0]      shamt_t;

  // alu_op_t fields
  localparam int ALU_WORD_BIT = 4;
  // sub, unsigned compare or arithmetic shift
  localparam int ALU_VAR_BIT  = 3;

  // ALU function codes, alu_op_t[2:0]
  localparam logic [2:0] ALU_ADD  = 3'd0;
  localparam logic [2:0] ALU_SLL  = 3'd1;
  localparam logic [2:0] ALU_SLT  = 3'd2;
  localparam logic [2:0] ALU_SRC2 = 3'd3;
  localparam logic [2:0] ALU_XOR  = 3'd4;
  localparam logic [2:0] ALU_SR   = 3'd5;
  localparam logic [2:0] ALU_OR   = 3'd6;
  localparam logic [2:0] ALU_AND  = 3'd7;

  // muldiv_op_t bit 2 selects the divider
  localparam int MD_DIV_BIT = 2;

  // multiply types
  localparam md_type_t MD_MUL    = 2'd0;
  localparam md_type_t MD_MULH   = 2'd1;
  localparam md_type_t MD_MULHSU = 2'd2;
  localparam md_type_t MD_MULHU  = 2'd3;

  // divide types
  localparam md_type_t MD_DIV  = 2'd0;
  localparam md_type_t MD_DIVU = 2'd1;
  localparam md_type_t MD_REM  = 2'd2;
  localparam md_type_t MD_REMU = 2'd3;

endpackage
